// ==== logic/wb_pkg.sv ====
/*
 * Wishbone bus definitions
 * Widths and vector types shared by the bus manager, the processor
 * and the tile top level
 */
package wb_pkg;

   // Bus widths, fixed by the interconnect
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W  = 4;

   // Byte address on the bus
   typedef logic [ADDR_W-1:0] addr_t;

   // One data word
   typedef logic [DATA_W-1:0] data_t;

   // Byte-lane select
   typedef logic [SEL_W-1:0] sel_t;

   // Full word, every lane on
   localparam sel_t SEL_WORD = 4'hF;

endpackage

// ==== logic/cpu_pkg.sv ====
/*
 * Accumulator processor definitions
 * Opcodes, instruction field positions and the reset vector
 */
package cpu_pkg;

   import wb_pkg::*;

   // Opcode field, top nibble of the instruction
   localparam int OP_MSB = 31;
   localparam int OP_LSB = 28;

   // Operand address or jump target, word aligned byte address
   localparam int ADDR_MSB = 15;
   localparam int ADDR_LSB = 0;

   // Codes not listed here run as a no-operation
   typedef enum logic [3:0] {
      OP_LDA = 4'h1,
      OP_ADD = 4'h2,
      OP_SUB = 4'h3,
      OP_STA = 4'h4,
      OP_JNZ = 4'h5,
      OP_HLT = 4'hF
   } opcode_t;

   // First fetch after reset
   localparam addr_t RESET_PC = 32'h0000_0000;

   // Program counter step, one word
   localparam addr_t PC_STEP = 32'd4;

endpackage

// ==== logic/wishbone_manager.sv ====
/*
 * Wishbone classic manager
 * Turns a one-cycle read or write strobe from the user logic into a
 * single Wishbone transfer, answered by a busy flag
 */
`timescale 1ns/1ps

module wishbone_manager import wb_pkg::*; (
   input  logic  clk,
   input  logic  reset_i,

   // User side request
   input  addr_t adr_i,
   input  data_t cpu_dat_i,
   input  sel_t  sel_i,
   input  logic  write_i,
   input  logic  read_i,

   // Bus side response
   input  data_t dat_i,
   input  logic  ack_i,

   // Bus side request
   output addr_t adr_o,
   output data_t dat_o,
   output sel_t  sel_o,
   output logic  we_o,
   output logic  stb_o,
   output logic  cyc_o,

   // User side response
   output data_t cpu_dat_o,
   output logic  busy_o
);

   typedef enum logic {
      IDLE,
      ACTIVE
   } wbm_state_t;

   wbm_state_t state;

   // Any strobe starts a transfer
   logic start;

   assign start = write_i | read_i;

   // Control path
   always_ff @(posedge clk) begin
      if (reset_i) begin
         state <= IDLE;
         we_o  <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state <= ACTIVE;
                  // Write wins if both strobes show up
                  we_o  <= write_i;
               end
            end
            ACTIVE: begin
               // Slave may stretch the cycle, outputs just hold
               if (ack_i) begin
                  state <= IDLE;
                  we_o  <= 1'b0;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Request payload, latched with the strobe
   always_ff @(posedge clk) begin
      if (state == IDLE && start) begin
         adr_o <= adr_i;
         dat_o <= cpu_dat_i;
         sel_o <= sel_i;
      end
   end

   // Read data, sampled in the ACK cycle and held until the next request
   always_ff @(posedge clk) begin
      if (state == ACTIVE && ack_i && !we_o) begin
         cpu_dat_o <= dat_i;
      end
   end

   // STB and CYC rise and fall together with busy
   assign stb_o  = (state == ACTIVE);
   assign cyc_o  = (state == ACTIVE);
   assign busy_o = (state == ACTIVE);

endmodule

// ==== logic/cpu.sv ====
/*
 * Accumulator processor
 * Fetches each instruction and its operand over the bus manager,
 * executes it on a 32-bit accumulator and stops on HLT
 */
`timescale 1ns/1ps

module cpu import wb_pkg::*, cpu_pkg::*; (
   input  logic  clk,
   input  logic  reset_i,
   input  logic  en_i,

   // From the bus manager
   input  logic  busy_i,
   input  data_t cpu_dat_i,

   // To the bus manager
   output data_t cpu_dat_o,
   output addr_t adr_o,
   output sel_t  sel_o,
   output logic  write_o,
   output logic  read_o,
   output logic  halted_o
);

   typedef enum logic [2:0] {
      S_FETCH_REQ,
      S_FETCH_WAIT,
      S_OPER_REQ,
      S_OPER_WAIT,
      S_EXEC,
      S_HALT
   } cpu_state_t;

   cpu_state_t state;

   addr_t pc;
   data_t ir;
   data_t acc;

   opcode_t op;
   opcode_t fetched_op;
   addr_t   target;

   // Memory operand needed for loads, arithmetic and stores
   function automatic logic needs_operand(input opcode_t code);
      return (code == OP_LDA) || (code == OP_ADD) ||
             (code == OP_SUB) || (code == OP_STA);
   endfunction

   // Decode the held instruction and the word arriving from the bus
   assign op         = opcode_t'(ir[OP_MSB:OP_LSB]);
   assign fetched_op = opcode_t'(cpu_dat_i[OP_MSB:OP_LSB]);

   // Operand or jump address, zero extended
   always_comb begin
      target = '0;
      target[ADDR_MSB:ADDR_LSB] = ir[ADDR_MSB:ADDR_LSB];
   end

   // Strobes only in request states and only while enabled
   assign read_o  = en_i && ((state == S_FETCH_REQ) ||
                             (state == S_OPER_REQ && op != OP_STA));
   assign write_o = en_i && (state == S_OPER_REQ) && (op == OP_STA);

   assign adr_o     = (state == S_FETCH_REQ) ? pc : target;
   assign cpu_dat_o = acc;
   assign sel_o     = SEL_WORD;
   assign halted_o  = (state == S_HALT);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state <= S_FETCH_REQ;
         pc    <= RESET_PC;
         acc   <= '0;
      end else begin
         case (state)
            S_FETCH_REQ: begin
               // Stall here while disabled
               if (en_i) state <= S_FETCH_WAIT;
            end
            S_FETCH_WAIT: begin
               // Falling busy, instruction word on cpu_dat_i
               if (!busy_i) begin
                  state <= needs_operand(fetched_op) ? S_OPER_REQ : S_EXEC;
               end
            end
            S_OPER_REQ: begin
               if (en_i) state <= S_OPER_WAIT;
            end
            S_OPER_WAIT: begin
               if (!busy_i) state <= S_EXEC;
            end
            S_EXEC: begin
               state <= S_FETCH_REQ;
               pc    <= pc + PC_STEP;
               case (op)
                  // Operand still held by the manager
                  OP_LDA: acc <= cpu_dat_i;
                  OP_ADD: acc <= acc + cpu_dat_i;
                  OP_SUB: acc <= acc - cpu_dat_i;
                  OP_JNZ: begin
                     if (acc != '0) pc <= target;
                  end
                  OP_HLT: state <= S_HALT;
                  // Store already done on the bus, others fall through
                  default: ;
               endcase
            end
            // Left only by reset
            S_HALT: state <= S_HALT;
            default: state <= S_FETCH_REQ;
         endcase
      end
   end

   // Instruction register, loaded when the fetch completes
   always_ff @(posedge clk) begin
      if (state == S_FETCH_WAIT && !busy_i) begin
         ir <= cpu_dat_i;
      end
   end

endmodule

// ==== logic/team_01.sv ====
/*
 * Student tile top level
 * Accumulator processor mastering the Wishbone bus through the
 * manager, halted flag on GPIO 0, logic analyzer unused
 */
`timescale 1ns/1ps

module team_01 import wb_pkg::*; (
   input  logic         clk,
   input  logic         reset_i,
   input  logic         en_i,

   // Logic analyzer
   input  logic [127:0] la_data_in_i,
   output logic [127:0] la_data_out_o,
   input  logic [127:0] la_oenb_i,

   // Breakout board pins, output enables active low
   input  logic [33:0]  gpio_in_i,
   output logic [33:0]  gpio_out_o,
   output logic [33:0]  gpio_oeb_o,

   // Wishbone manager side
   input  data_t        dat_i,
   input  logic         ack_i,
   output addr_t        adr_o,
   output data_t        dat_o,
   output sel_t         sel_o,
   output logic         we_o,
   output logic         stb_o,
   output logic         cyc_o
);

   // Request path between processor and manager
   addr_t req_adr;
   data_t req_dat_w;
   data_t req_dat_r;
   sel_t  req_sel;
   logic  req_write;
   logic  req_read;
   logic  req_busy;
   logic  halted;

   assign la_data_out_o = '0;

   // Only pin 0 drives, the rest stay inputs
   assign gpio_out_o = {33'b0, halted};
   assign gpio_oeb_o = {{33{1'b1}}, 1'b0};

   wishbone_manager wb_manager (
      .clk       (clk),
      .reset_i   (reset_i),
      .adr_i     (req_adr),
      .cpu_dat_i (req_dat_w),
      .sel_i     (req_sel),
      .write_i   (req_write),
      .read_i    (req_read),
      .dat_i     (dat_i),
      .ack_i     (ack_i),
      .adr_o     (adr_o),
      .dat_o     (dat_o),
      .sel_o     (sel_o),
      .we_o      (we_o),
      .stb_o     (stb_o),
      .cyc_o     (cyc_o),
      .cpu_dat_o (req_dat_r),
      .busy_o    (req_busy)
   );

   cpu cpu_core (
      .clk       (clk),
      .reset_i   (reset_i),
      .en_i      (en_i),
      .busy_i    (req_busy),
      .cpu_dat_i (req_dat_r),
      .cpu_dat_o (req_dat_w),
      .adr_o     (req_adr),
      .sel_o     (req_sel),
      .write_o   (req_write),
      .read_o    (req_read),
      .halted_o  (halted)
   );

endmodule

// ==== sim/wb_mem_model.sv ====
/*
 * Wishbone slave memory model
 * 64 words holding the summing program, with a random 0 to 3 cycle
 * acknowledge delay per transfer
 */
`timescale 1ns/1ps

module wb_mem_model import wb_pkg::*, cpu_pkg::*; (
   input  logic  clk,
   input  logic  reset_i,
   input  addr_t adr_i,
   input  data_t dat_i,
   input  sel_t  sel_i,
   input  logic  we_i,
   input  logic  stb_i,
   input  logic  cyc_i,
   output data_t dat_o,
   output logic  ack_o
);

   localparam int WORDS = 64;

   // Data words after the code
   localparam addr_t N_ADR      = 32'h40;
   localparam addr_t ONE_ADR    = 32'h44;
   localparam addr_t SUM_ADR    = 32'h48;
   localparam addr_t RESULT_ADR = 32'h4C;

   data_t      mem [WORDS];
   int         seed = 32'h008ea5c3;
   logic [1:0] delay;
   logic [1:0] waited;
   logic [5:0] idx;

   assign idx = adr_i[7:2];

   // Opcode nibble, zero gap, 16-bit address field
   function automatic data_t instr(input opcode_t op, input addr_t a);
      return {op, 12'h000, a[15:0]};
   endfunction

   initial begin
      // Filler with a no-op opcode, tagged with its own address
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = {16'hA5C0, 16'(i * 4)};
      end
      // sum += n, n -= 1, loop while n is nonzero
      mem[0]  = instr(OP_LDA, SUM_ADR);
      mem[1]  = instr(OP_ADD, N_ADR);
      mem[2]  = instr(OP_STA, SUM_ADR);
      mem[3]  = instr(OP_LDA, N_ADR);
      mem[4]  = instr(OP_SUB, ONE_ADR);
      mem[5]  = instr(OP_STA, N_ADR);
      mem[6]  = instr(OP_JNZ, 32'h00);
      // Loop done, copy the sum out and stop
      mem[7]  = instr(OP_LDA, SUM_ADR);
      mem[8]  = instr(OP_STA, RESULT_ADR);
      mem[9]  = instr(OP_HLT, 32'h00);
      mem[N_ADR[7:2]]      = 32'd5;
      mem[ONE_ADR[7:2]]    = 32'd1;
      mem[SUM_ADR[7:2]]    = 32'd0;
      mem[RESULT_ADR[7:2]] = 32'd0;
   end

   always @(posedge clk) begin : ack_gen
      int r;
      r = $random(seed);
      if (reset_i) begin
         ack_o  <= 1'b0;
         dat_o  <= '0;
         waited <= '0;
         delay  <= 2'(r);
      end else if (ack_o) begin
         // One-cycle ACK, new delay for the next transfer
         ack_o  <= 1'b0;
         waited <= '0;
         delay  <= 2'(r);
      end else if (cyc_i && stb_i) begin
         if (waited == delay) begin
            ack_o <= 1'b1;
            if (we_i) begin
               for (int b = 0; b < 4; b++) begin
                  if (sel_i[b]) mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
               end
            end else begin
               dat_o <= mem[idx];
            end
         end else begin
            waited <= waited + 2'd1;
         end
      end
   end

endmodule

// ==== sim/tb_team_01.sv ====
/*
 * Tile testbench
 * Runs the summing program out of the bus memory model and checks bus
 * protocol, reset state, transfer sequence, enable gating and halt
 */
`timescale 1ns/1ps

module tb_team_01 import wb_pkg::*, cpu_pkg::*; ();

   localparam int RESET_CYCLES = 16;
   // 70 transfers at up to six cycles each, plus reset, pause and margin
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int PAUSE_AFTER = 30;
   localparam int PAUSE_CYCLES = 40;
   localparam data_t SUM_EXPECTED = 32'd15;

   logic         clk;
   logic         reset_i;
   logic         en_i;
   logic [127:0] la_data_in_i;
   logic [127:0] la_data_out_o;
   logic [127:0] la_oenb_i;
   logic [33:0]  gpio_in_i;
   logic [33:0]  gpio_out_o;
   logic [33:0]  gpio_oeb_o;
   data_t        dat_i;
   data_t        dat_o;
   addr_t        adr_o;
   sel_t         sel_o;
   logic         ack_i;
   logic         we_o;
   logic         stb_o;
   logic         cyc_o;

   // Expected transfers in bus order
   logic  exp_we_q [$];
   addr_t exp_adr_q [$];
   data_t exp_dat_q [$];
   addr_t result_adr;
   int    total_expected = 0;

   int mismatch_count = 0;
   int failure_count = 0;
   int acks_seen = 0;
   int cycle_cnt = 0;

   // Last-edge copies for the protocol checks
   logic  rst_d = 1'b0;
   logic  cyc_d = 1'b0;
   logic  ack_d = 1'b0;
   logic  en_d = 1'b1;
   logic  halt_d = 1'b0;
   logic  first_seen = 1'b0;
   addr_t adr_d;
   data_t dat_d;
   logic  we_d;

   team_01 uut (
      .clk           (clk),
      .reset_i       (reset_i),
      .en_i          (en_i),
      .la_data_in_i  (la_data_in_i),
      .la_data_out_o (la_data_out_o),
      .la_oenb_i     (la_oenb_i),
      .gpio_in_i     (gpio_in_i),
      .gpio_out_o    (gpio_out_o),
      .gpio_oeb_o    (gpio_oeb_o),
      .dat_i         (dat_i),
      .ack_i         (ack_i),
      .adr_o         (adr_o),
      .dat_o         (dat_o),
      .sel_o         (sel_o),
      .we_o          (we_o),
      .stb_o         (stb_o),
      .cyc_o         (cyc_o)
   );

   wb_mem_model mem_model (
      .clk     (clk),
      .reset_i (reset_i),
      .adr_i   (adr_o),
      .dat_i   (dat_o),
      .sel_i   (sel_o),
      .we_i    (we_o),
      .stb_i   (stb_o),
      .cyc_i   (cyc_o),
      .dat_o   (dat_i),
      .ack_o   (ack_i)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                  input logic [63:0] got_v);
      $display("Mismatch at %0t: %s expected %0h got %0h", $time, sig, exp_v, got_v);
      mismatch_count++;
   endtask

   task automatic flag_failure(input string what);
      $display("Error at %0t: %s", $time, what);
      failure_count++;
   endtask

   task automatic expect_transfer(input logic we, input addr_t adr, input data_t dat);
      exp_we_q.push_back(we);
      exp_adr_q.push_back(adr);
      exp_dat_q.push_back(dat);
      total_expected++;
   endtask

   // Instruction-level run of the preloaded program
   task automatic build_expected();
      data_t ref_mem [64];
      addr_t pc;
      addr_t tgt;
      data_t acc;
      data_t ins;
      logic  done;
      int    steps;
      for (int i = 0; i < 64; i++) begin
         ref_mem[i] = mem_model.mem[i];
      end
      pc = RESET_PC;
      acc = '0;
      done = 1'b0;
      steps = 0;
      while (!done && steps < 200) begin
         ins = ref_mem[pc[7:2]];
         tgt = {16'h0000, ins[ADDR_MSB:ADDR_LSB]};
         expect_transfer(1'b0, pc, '0);
         pc = pc + 32'd4;
         steps++;
         case (ins[31:28])
            OP_LDA: begin
               expect_transfer(1'b0, tgt, '0);
               acc = ref_mem[tgt[7:2]];
            end
            OP_ADD: begin
               expect_transfer(1'b0, tgt, '0);
               acc = acc + ref_mem[tgt[7:2]];
            end
            OP_SUB: begin
               expect_transfer(1'b0, tgt, '0);
               acc = acc - ref_mem[tgt[7:2]];
            end
            OP_STA: begin
               expect_transfer(1'b1, tgt, acc);
               ref_mem[tgt[7:2]] = acc;
               result_adr = tgt;
            end
            // Taken only on a nonzero accumulator
            OP_JNZ: begin
               if (acc != '0) pc = tgt;
            end
            OP_HLT: done = 1'b1;
            default: ;
         endcase
      end
   endtask

   // Compare one acknowledged transfer with the head of the queue
   task automatic check_transfer();
      if (exp_adr_q.size() == 0) begin
         flag_failure("transfer beyond the end of the program");
      end else begin
         assert (we_o === exp_we_q[0])
            else report_mismatch("we_o", 64'(exp_we_q[0]), 64'(we_o));
         assert (adr_o === exp_adr_q[0])
            else report_mismatch("adr_o", 64'(exp_adr_q[0]), 64'(adr_o));
         if (exp_we_q[0]) begin
            assert (dat_o === exp_dat_q[0])
               else report_mismatch("dat_o", 64'(exp_dat_q[0]), 64'(dat_o));
         end
         void'(exp_we_q.pop_front());
         void'(exp_adr_q.pop_front());
         void'(exp_dat_q.pop_front());
      end
   endtask

   task automatic print_summary();
      $display("Summary: %0d mismatches, %0d other errors, %0d of %0d transfers seen",
               mismatch_count, failure_count, acks_seen, total_expected);
   endtask

   // Bus monitor sampled on the rising edge
   always @(posedge clk) begin
      // Outputs reflect reset from the second reset edge on
      if (rst_d) begin
         assert (!stb_o && !cyc_o && !we_o && !gpio_out_o[0])
            else flag_failure("bus strobes or halted flag active in reset");
      end
      if (!reset_i) begin
         assert (stb_o === cyc_o) else report_mismatch("stb_o", 64'(cyc_o), 64'(stb_o));
         if (cyc_o) begin
            assert (sel_o === SEL_WORD)
               else report_mismatch("sel_o", 64'(SEL_WORD), 64'(sel_o));
         end
         if (cyc_o && !cyc_d && !first_seen) begin
            first_seen <= 1'b1;
            assert (!we_o && adr_o === RESET_PC)
               else flag_failure("first transfer is not a read at the reset vector");
         end
         // Nothing may move in a held cycle until ACK
         if (cyc_d && !ack_d) begin
            assert (cyc_o) else flag_failure("cycle dropped before acknowledge");
            if (cyc_o) begin
               assert (adr_o === adr_d) else report_mismatch("adr_o", 64'(adr_d), 64'(adr_o));
               assert (dat_o === dat_d) else report_mismatch("dat_o", 64'(dat_d), 64'(dat_o));
               assert (we_o === we_d) else report_mismatch("we_o", 64'(we_d), 64'(we_o));
            end
         end
         if (ack_d) begin
            assert (!stb_o) else flag_failure("stb_o still high the cycle after ACK");
         end
         assert (en_d || !cyc_o || cyc_d)
            else flag_failure("transfer started while disabled");
         assert (!(gpio_out_o[0] && cyc_o)) else flag_failure("bus cycle after halt");
         if (gpio_out_o[0] && !halt_d) begin
            assert (exp_adr_q.size() == 0) else flag_failure("halted before the HLT fetch");
         end
         if (cyc_o && ack_i) begin
            check_transfer();
            acks_seen <= acks_seen + 1;
         end
      end
      rst_d  <= reset_i;
      cyc_d  <= cyc_o;
      ack_d  <= cyc_o && ack_i;
      en_d   <= en_i;
      halt_d <= gpio_out_o[0];
      adr_d  <= adr_o;
      dat_d  <= dat_o;
      we_d   <= we_o;
   end

   // Watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         flag_failure("run did not reach halt before the cycle limit");
         print_summary();
         $display("Testbench failed");
         $finish;
      end
   end

   initial begin
      $timeformat(-9, 0, " ns", 0);
      reset_i = 1'b1;
      en_i = 1'b1;
      la_data_in_i = '0;
      la_oenb_i = '1;
      gpio_in_i = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      build_expected();
      reset_i = 1'b0;
      // Mid-run pause
      while (acks_seen < PAUSE_AFTER) @(posedge clk);
      #1 en_i = 1'b0;
      repeat (PAUSE_CYCLES) @(posedge clk);
      assert (!cyc_o) else flag_failure("bus still busy at the end of the disabled window");
      #1 en_i = 1'b1;
      while (!gpio_out_o[0]) @(posedge clk);
      repeat (20) @(posedge clk);
      // Final state after halt
      assert (exp_adr_q.size() == 0) else flag_failure("program ended with transfers missing");
      assert (mem_model.mem[result_adr[7:2]] === SUM_EXPECTED)
         else report_mismatch("result word", 64'(SUM_EXPECTED),
                              64'(mem_model.mem[result_adr[7:2]]));
      assert (gpio_oeb_o === {{33{1'b1}}, 1'b0})
         else report_mismatch("gpio_oeb_o", 64'({{33{1'b1}}, 1'b0}), 64'(gpio_oeb_o));
      assert (la_data_out_o === '0) else flag_failure("logic analyzer outputs not tied low");
      print_summary();
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
logic/wb_pkg.sv
logic/cpu_pkg.sv
logic/wishbone_manager.sv
logic/cpu.sv
logic/team_01.sv
sim/wb_mem_model.sv
sim/tb_team_01.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
TOP        := tb_team_01
RTL_TOP    := team_01
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
